// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_implied_core
FLAGS     ?= --binary --timing --assert
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f

SOURCES := $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+tests
src/cpu_pkg.sv
src/step_sequencer.sv
src/implied_decoder.sv
src/alu.sv
src/register_file.sv
src/status_register.sv
src/program_counter.sv
src/implied_core.sv
tests/tb_implied_core.sv

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  byte_t sb_bus,
    input  byte_t db_bus,
    input  logic  carry,
    output byte_t alu_result,
    output logic  alu_carry
);

    byte_t      a_in;
    logic       cin;
    logic [8:0] sum;
    byte_t      res_next;
    logic       carry_next;

    assign a_in = (ctrl.alu_a == ALU_A_ZERO) ? 8'h00 : sb_bus;

    always_comb begin
        case (ctrl.carry_in)
            CIN_ONE: cin = 1'b1;
            CIN_C:   cin = carry;
            default: cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a_in} + {1'b0, db_bus} + {8'h00, cin};

    always_comb begin
        if (ctrl.alu_op == ALU_ROT) begin
            // Carry in enters at bit 7, bit 0 falls out
            res_next   = {cin, a_in[7:1]};
            carry_next = a_in[0];
        end else begin
            res_next   = sum[7:0];
            carry_next = sum[8];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_result <= 8'h00;
            alu_carry  <= 1'b0;
        end else if (ctrl.alu_op != ALU_NONE) begin
            alu_result <= res_next;
            alu_carry  <= carry_next;
        end
    end

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    localparam byte_t SP_RESET = 8'hFF;
    localparam addr_t PC_RESET = 16'h0000;

    // Accumulator shifts and rotates
    localparam byte_t OP_ASL_A = 8'h0A;
    localparam byte_t OP_ROL_A = 8'h2A;
    localparam byte_t OP_LSR_A = 8'h4A;
    localparam byte_t OP_ROR_A = 8'h6A;

    // Index increments and decrements
    localparam byte_t OP_INX = 8'hE8;
    localparam byte_t OP_INY = 8'hC8;
    localparam byte_t OP_DEX = 8'hCA;
    localparam byte_t OP_DEY = 8'h88;

    // Register transfers
    localparam byte_t OP_TAX = 8'hAA;
    localparam byte_t OP_TAY = 8'hA8;
    localparam byte_t OP_TXA = 8'h8A;
    localparam byte_t OP_TYA = 8'h98;
    localparam byte_t OP_TSX = 8'hBA;
    localparam byte_t OP_TXS = 8'h9A;

    // Flag set and clear
    localparam byte_t OP_SEC = 8'h38;
    localparam byte_t OP_SED = 8'hF8;
    localparam byte_t OP_SEI = 8'h78;
    localparam byte_t OP_CLC = 8'h18;
    localparam byte_t OP_CLD = 8'hD8;
    localparam byte_t OP_CLI = 8'h58;
    localparam byte_t OP_CLV = 8'hB8;

    localparam byte_t OP_NOP = 8'hEA;

    typedef enum logic [1:0] {IDLE, T0, T1} step_e;

    typedef enum logic [2:0] {SB_NONE, SB_ACC, SB_X, SB_Y, SB_SP, SB_ALU} sb_src_e;
    typedef enum logic [1:0] {DB_NONE, DB_ACC, DB_SB, DB_ONES} db_src_e;
    typedef enum logic {ALU_A_SB, ALU_A_ZERO} alu_a_e;
    typedef enum logic [1:0] {ALU_NONE, ALU_ADD, ALU_ROT} alu_op_e;
    typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_C} carry_in_e;
    typedef enum logic [2:0] {LD_NONE, LD_ACC, LD_X, LD_Y, LD_SP} reg_load_e;
    typedef enum logic [2:0] {PSR_NONE, PSR_C, PSR_D, PSR_I, PSR_V} psr_sel_e;

    typedef struct packed {
        sb_src_e   sb_src;
        db_src_e   db_src;
        alu_a_e    alu_a;
        alu_op_e   alu_op;
        carry_in_e carry_in;
        reg_load_e reg_load;
        logic      upd_nz;
        logic      upd_c;
        psr_sel_e  psr_sel;
        logic      psr_value;
        logic      pc_step;
    } ctrl_t;

    typedef struct packed {
        byte_t a;
        byte_t x;
        byte_t y;
        byte_t sp;
    } regs_t;

    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

endpackage

`default_nettype wire

// File: src/implied_core.sv
`timescale 1ns/1ps
`default_nettype none

module implied_core import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    op_valid,
    input  byte_t   opcode,
    output logic    busy,
    output regs_t   regs,
    output status_t status,
    output addr_t   addr
);

    step_e step;
    byte_t op_latched;
    ctrl_t ctrl;
    byte_t sb_bus;
    byte_t db_bus;
    byte_t alu_result;
    logic  alu_carry;

    step_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (op_valid),
        .opcode     (opcode),
        .step       (step),
        .op_latched (op_latched),
        .busy       (busy)
    );

    implied_decoder u_dec (
        .step       (step),
        .op_latched (op_latched),
        .ctrl       (ctrl)
    );

    alu u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .sb_bus     (sb_bus),
        .db_bus     (db_bus),
        .carry      (status.c),
        .alu_result (alu_result),
        .alu_carry  (alu_carry)
    );

    register_file u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .sb_bus     (sb_bus),
        .db_bus     (db_bus),
        .regs       (regs)
    );

    status_register u_psr (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .sb_bus     (sb_bus),
        .alu_carry  (alu_carry),
        .status     (status)
    );

    program_counter u_pc (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .addr       (addr)
    );

endmodule

`default_nettype wire

// File: src/implied_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module implied_decoder import cpu_pkg::*; (
    input  step_e step,
    input  byte_t op_latched,
    output ctrl_t ctrl
);

    ctrl_t     t0;
    reg_load_e wb_reg;

    function automatic ctrl_t alu_word(sb_src_e sb, db_src_e db, alu_a_e a, carry_in_e cin,
                                       alu_op_e op);
        ctrl_t w;
        w          = '0;
        w.sb_src   = sb;
        w.db_src   = db;
        w.alu_a    = a;
        w.carry_in = cin;
        w.alu_op   = op;
        return w;
    endfunction

    function automatic ctrl_t xfer_word(sb_src_e sb, reg_load_e dst, logic nz);
        ctrl_t w;
        w          = '0;
        w.sb_src   = sb;
        w.reg_load = dst;
        w.upd_nz   = nz;
        return w;
    endfunction

    function automatic ctrl_t flag_word(psr_sel_e sel, logic value);
        ctrl_t w;
        w           = '0;
        w.psr_sel   = sel;
        w.psr_value = value;
        return w;
    endfunction

    // T0 control word per opcode, unknown opcodes fall through as NOP
    always_comb begin
        case (op_latched)
            OP_ASL_A: t0 = alu_word(SB_ACC, DB_ACC,  ALU_A_SB,   CIN_ZERO, ALU_ADD);
            OP_ROL_A: t0 = alu_word(SB_ACC, DB_ACC,  ALU_A_SB,   CIN_C,    ALU_ADD);
            OP_LSR_A: t0 = alu_word(SB_ACC, DB_NONE, ALU_A_SB,   CIN_ZERO, ALU_ROT);
            OP_ROR_A: t0 = alu_word(SB_ACC, DB_NONE, ALU_A_SB,   CIN_C,    ALU_ROT);
            // Decrement adds FF, increment adds 0 plus carry in
            OP_DEX:   t0 = alu_word(SB_X,   DB_ONES, ALU_A_SB,   CIN_ZERO, ALU_ADD);
            OP_DEY:   t0 = alu_word(SB_Y,   DB_ONES, ALU_A_SB,   CIN_ZERO, ALU_ADD);
            OP_INX:   t0 = alu_word(SB_X,   DB_SB,   ALU_A_ZERO, CIN_ONE,  ALU_ADD);
            OP_INY:   t0 = alu_word(SB_Y,   DB_SB,   ALU_A_ZERO, CIN_ONE,  ALU_ADD);
            OP_TAX:   t0 = xfer_word(SB_ACC, LD_X,   1'b1);
            OP_TAY:   t0 = xfer_word(SB_ACC, LD_Y,   1'b1);
            OP_TXA:   t0 = xfer_word(SB_X,   LD_ACC, 1'b1);
            OP_TYA:   t0 = xfer_word(SB_Y,   LD_ACC, 1'b1);
            OP_TSX:   t0 = xfer_word(SB_SP,  LD_X,   1'b1);
            // TXS leaves N and Z alone
            OP_TXS:   t0 = xfer_word(SB_X,   LD_SP,  1'b0);
            OP_SEC:   t0 = flag_word(PSR_C, 1'b1);
            OP_SED:   t0 = flag_word(PSR_D, 1'b1);
            OP_SEI:   t0 = flag_word(PSR_I, 1'b1);
            OP_CLC:   t0 = flag_word(PSR_C, 1'b0);
            OP_CLD:   t0 = flag_word(PSR_D, 1'b0);
            OP_CLI:   t0 = flag_word(PSR_I, 1'b0);
            OP_CLV:   t0 = flag_word(PSR_V, 1'b0);
            default:  t0 = '0;
        endcase
    end

    // ALU ops write back into the register they read from
    always_comb begin
        case (t0.sb_src)
            SB_ACC:  wb_reg = LD_ACC;
            SB_X:    wb_reg = LD_X;
            SB_Y:    wb_reg = LD_Y;
            default: wb_reg = LD_NONE;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (step)
            T0: ctrl = t0;
            T1: begin
                ctrl.pc_step = 1'b1;
                if (t0.alu_op != ALU_NONE) begin
                    ctrl.sb_src   = SB_ALU;
                    ctrl.reg_load = wb_reg;
                    ctrl.upd_nz   = 1'b1;
                    // Only the accumulator shifts touch C
                    ctrl.upd_c    = (t0.sb_src == SB_ACC);
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    output addr_t addr
);

    addr_t pc;
    addr_t pc_inc;
    byte_t abh;
    byte_t abl;

    assign pc_inc = pc + 16'd1;
    assign addr   = {abh, abl};

    // Address latches pick up the incremented PC in the same step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= PC_RESET;
            abh <= PC_RESET[15:8];
            abl <= PC_RESET[7:0];
        end else if (ctrl.pc_step) begin
            pc  <= pc_inc;
            abh <= pc_inc[15:8];
            abl <= pc_inc[7:0];
        end
    end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  byte_t alu_result,
    output byte_t sb_bus,
    output byte_t db_bus,
    output regs_t regs
);

    regs_t r;

    assign regs = r;

    // Stack bus source
    always_comb begin
        case (ctrl.sb_src)
            SB_ACC:  sb_bus = r.a;
            SB_X:    sb_bus = r.x;
            SB_Y:    sb_bus = r.y;
            SB_SP:   sb_bus = r.sp;
            SB_ALU:  sb_bus = alu_result;
            default: sb_bus = 8'h00;
        endcase
    end

    // Data bus source, SB can be bridged across
    always_comb begin
        case (ctrl.db_src)
            DB_ACC:  db_bus = r.a;
            DB_SB:   db_bus = sb_bus;
            DB_ONES: db_bus = 8'hFF;
            default: db_bus = 8'h00;
        endcase
    end

    // Transfers in T0 and ALU writeback in T1 both load from SB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r.a  <= 8'h00;
            r.x  <= 8'h00;
            r.y  <= 8'h00;
            r.sp <= SP_RESET;
        end else begin
            case (ctrl.reg_load)
                LD_ACC:  r.a  <= sb_bus;
                LD_X:    r.x  <= sb_bus;
                LD_Y:    r.y  <= sb_bus;
                LD_SP:   r.sp <= sb_bus;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/status_register.sv
`timescale 1ns/1ps
`default_nettype none

module status_register import cpu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  ctrl_t   ctrl,
    input  byte_t   sb_bus,
    input  logic    alu_carry,
    output status_t status
);

    status_t p;

    assign status = p;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p <= '0;
        end else begin
            // Explicit set and clear
            case (ctrl.psr_sel)
                PSR_C:   p.c <= ctrl.psr_value;
                PSR_D:   p.d <= ctrl.psr_value;
                PSR_I:   p.i <= ctrl.psr_value;
                PSR_V:   p.v <= ctrl.psr_value;
                default: ;
            endcase

            // N and Z follow whatever is written over SB
            if (ctrl.upd_nz) begin
                p.n <= sb_bus[7];
                p.z <= (sb_bus == 8'h00);
            end

            if (ctrl.upd_c) begin
                p.c <= alu_carry;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  op_valid,
    input  byte_t opcode,
    output step_e step,
    output byte_t op_latched,
    output logic  busy
);

    logic accept;

    // Strobes only count while idle
    assign accept = op_valid && (step == IDLE);
    assign busy   = (step != IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step <= IDLE;
        end else begin
            case (step)
                IDLE:    step <= accept ? T0 : IDLE;
                T0:      step <= T1;
                default: step <= IDLE;
            endcase
        end
    end

    // Opcode held for both steps
    always_ff @(posedge clk) begin
        if (accept) begin
            op_latched <= opcode;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_model.svh
// Expected architectural state, advanced once per instruction

regs_t   exp_regs;
status_t exp_status;
addr_t   exp_addr;

// Opcodes that have a meaning for this unit, NOP included
function automatic logic is_listed_opcode(byte_t op);
    case (op)
        OP_ASL_A, OP_ROL_A, OP_LSR_A, OP_ROR_A,
        OP_INX, OP_INY, OP_DEX, OP_DEY,
        OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS,
        OP_SEC, OP_SED, OP_SEI, OP_CLC, OP_CLD, OP_CLI, OP_CLV,
        OP_NOP:  return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic model_reset();
    exp_regs.a  = 8'h00;
    exp_regs.x  = 8'h00;
    exp_regs.y  = 8'h00;
    exp_regs.sp = SP_RESET;
    exp_status  = '0;
    exp_addr    = PC_RESET;
endtask

task automatic load_nz(byte_t value);
    exp_status.n = value[7];
    exp_status.z = (value == 8'h00);
endtask

task automatic model_step(byte_t op);
    byte_t a;
    logic  c;
    a = exp_regs.a;
    c = exp_status.c;
    case (op)
        // Nine-bit shifts through C
        OP_ASL_A: {exp_status.c, exp_regs.a} = {a, 1'b0};
        OP_ROL_A: {exp_status.c, exp_regs.a} = {a, c};
        OP_LSR_A: {exp_regs.a, exp_status.c} = {1'b0, a};
        OP_ROR_A: {exp_regs.a, exp_status.c} = {c, a};
        OP_INX:   exp_regs.x = exp_regs.x + 8'd1;
        OP_INY:   exp_regs.y = exp_regs.y + 8'd1;
        OP_DEX:   exp_regs.x = exp_regs.x - 8'd1;
        OP_DEY:   exp_regs.y = exp_regs.y - 8'd1;
        OP_TAX:   exp_regs.x = exp_regs.a;
        OP_TAY:   exp_regs.y = exp_regs.a;
        OP_TXA:   exp_regs.a = exp_regs.x;
        OP_TYA:   exp_regs.a = exp_regs.y;
        OP_TSX:   exp_regs.x = exp_regs.sp;
        OP_TXS:   exp_regs.sp = exp_regs.x;
        OP_SEC:   exp_status.c = 1'b1;
        OP_SED:   exp_status.d = 1'b1;
        OP_SEI:   exp_status.i = 1'b1;
        OP_CLC:   exp_status.c = 1'b0;
        OP_CLD:   exp_status.d = 1'b0;
        OP_CLI:   exp_status.i = 1'b0;
        OP_CLV:   exp_status.v = 1'b0;
        default:  ;
    endcase
    // N and Z follow the destination, TXS has none
    case (op)
        OP_ASL_A, OP_ROL_A, OP_LSR_A, OP_ROR_A, OP_TXA, OP_TYA: load_nz(exp_regs.a);
        OP_INX, OP_DEX, OP_TAX, OP_TSX: load_nz(exp_regs.x);
        OP_INY, OP_DEY, OP_TAY:         load_nz(exp_regs.y);
        default: ;
    endcase
    exp_addr = exp_addr + 16'd1;
endtask

// File: tests/tb_implied_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_implied_core import cpu_pkg::*; ();

    localparam int PERIOD           = 100;
    localparam int XFER_OPS         = 60;
    localparam int SHIFT_ROUNDS     = 6;
    localparam int SHIFTS_PER_ROUND = 6;
    localparam int FLAG_RANDOM_OPS  = 21;
    localparam int PC_OPS           = 16;
    // Four seed ops, 16 ops per accumulator load, one ordered pass over the flag ops
    localparam int NUM_OPS = 4 + XFER_OPS + SHIFT_ROUNDS * (16 + 2 * SHIFTS_PER_ROUND)
                           + 7 + FLAG_RANDOM_OPS + PC_OPS;

    localparam byte_t XFER_SET [10] = '{OP_INX, OP_INY, OP_DEX, OP_DEY, OP_TAX,
                                        OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS};
    localparam byte_t SHIFT_SET [4] = '{OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A};
    localparam byte_t FLAG_SET [7]  = '{OP_SEC, OP_SED, OP_SEI, OP_CLC, OP_CLD, OP_CLI,
                                        OP_CLV};

    logic    clk;
    logic    arst_n;
    logic    op_valid;
    byte_t   opcode;
    logic    busy;
    regs_t   regs;
    status_t status;
    addr_t   addr;
    integer  seed;

    `include "tb_model.svh"

    implied_core dut (.*);

    task automatic stop_run(string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic value_error(string msg);
        stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Busy is high for exactly two cycles
    busy_holds: assert property (@(posedge clk) disable iff (!arst_n) $rose(busy) |=> busy)
        else value_error("busy fell after one cycle");
    busy_ends: assert property (@(posedge clk) disable iff (!arst_n)
                                busy && $past(busy) |=> !busy)
        else value_error("busy stayed high for more than two cycles");

    task automatic check_state(string tag);
        assert (regs == exp_regs)
            else value_error($sformatf("%s: a/x/y/sp %h, expected %h", tag, regs, exp_regs));
        assert (status == exp_status)
            else value_error($sformatf("%s: nvdizc %b, expected %b", tag, status, exp_status));
        assert (addr == exp_addr)
            else value_error($sformatf("%s: addr %h, expected %h", tag, addr, exp_addr));
    endtask

    // Called on a falling edge with the unit idle
    task automatic run_op(byte_t op);
        int   busy_cycles;
        logic inject;
        inject      = (rand_below(4) == 0);
        busy_cycles = 0;
        opcode      = op;
        op_valid    = 1'b1;
        @(negedge clk);
        assert (busy) else value_error($sformatf("opcode %h: busy did not rise", op));
        while (busy) begin
            busy_cycles++;
            // Stray strobe with another opcode, must be ignored
            op_valid = inject;
            opcode   = inject ? rand_byte() : op;
            @(negedge clk);
        end
        op_valid = 1'b0;
        assert (busy_cycles == 2)
            else value_error($sformatf("opcode %h: busy high for %0d cycles", op, busy_cycles));
        model_step(op);
        check_state($sformatf("opcode %h", op));
    endtask

    // Shifts the value in through C, MSB first
    task automatic load_accumulator(byte_t value);
        int b;
        for (b = 7; b >= 0; b--) begin
            run_op(value[b] ? OP_SEC : OP_CLC);
            run_op(OP_ROL_A);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_OPS * 4 + 20) * PERIOD);
        stop_run("Timeout: the watchdog expired before all instructions were run");
    end

    initial begin
        byte_t op;
        int    i;
        int    j;
        seed     = 32'h71ce;
        arst_n   = 1'b0;
        op_valid = 1'b0;
        opcode   = 8'h00;
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!busy) else value_error("busy is high after reset");
        check_state("after reset");

        // Known values first, then a random walk over index ops and transfers
        run_op(OP_TSX);
        run_op(OP_TXA);
        run_op(OP_DEY);
        run_op(OP_DEX);
        for (i = 0; i < XFER_OPS; i++) begin
            run_op(XFER_SET[rand_below(10)]);
        end

        for (i = 0; i < SHIFT_ROUNDS; i++) begin
            load_accumulator(rand_byte());
            for (j = 0; j < SHIFTS_PER_ROUND; j++) begin
                run_op((rand_below(2) == 0) ? OP_SEC : OP_CLC);
                run_op(SHIFT_SET[rand_below(4)]);
            end
        end

        for (i = 0; i < 7; i++) begin
            run_op(FLAG_SET[i]);
        end
        for (i = 0; i < FLAG_RANDOM_OPS; i++) begin
            run_op(FLAG_SET[rand_below(7)]);
        end

        // NOP alternates with opcodes outside the instruction set
        for (i = 0; i < PC_OPS; i++) begin
            if (i % 2 == 0) begin
                op = OP_NOP;
            end else begin
                op = rand_byte();
                while (is_listed_opcode(op)) begin
                    op = op + 8'd1;
                end
            end
            run_op(op);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
